//--- Bender.yml
package:
  name: uop_sequencer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uop_pkg.sv
      - hdl/uop_ctrl_fsm.sv
      - hdl/upc_counter.sv
      - hdl/ucode_rom.sv
      - hdl/uop_compose.sv
      - hdl/uop_sequencer_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/uop_seq_tb.sv

//--- dv/uop_seq_tb.sv
`timescale 1ns/1ps

`include "uop_defs.svh"

module uop_seq_tb;

    import uop_pkg::*;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        in_valid;
    logic                        in_ready;
    logic [`UOP_UUID_W-1:0]      in_uuid;
    logic [`UOP_NUM_THREADS-1:0] in_tmask;
    inst_word_u                  in_inst;
    logic                        out_valid;
    logic                        out_ready;
    logic [`UOP_UUID_W-1:0]      out_uuid;
    logic [`UOP_NUM_THREADS-1:0] out_tmask;
    inst_word_u                  out_inst;

    // instructions to send and transfers to expect, both in trace order
    logic [`UOP_UUID_W-1:0]      in_uuid_q[$];
    logic [`UOP_NUM_THREADS-1:0] in_tmask_q[$];
    inst_word_u                  in_inst_q[$];
    logic [`UOP_UUID_W-1:0]      exp_uuid_q[$];
    logic [`UOP_NUM_THREADS-1:0] exp_tmask_q[$];
    inst_word_u                  exp_inst_q[$];

    int          inst_errors  = 0;
    int          tag_errors   = 0;
    int          other_errors = 0;
    int          in_idx       = 0;
    int          in_count     = 0;
    int          out_count    = 0;
    logic        in_taken     = 1'b0;
    logic [31:0] lfsr         = 32'h4dc5fae4;

    uop_sequencer_top i_uop_sequencer_top (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_uuid   (in_uuid),
        .in_tmask  (in_tmask),
        .in_inst   (in_inst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_uuid  (out_uuid),
        .out_tmask (out_tmask),
        .out_inst  (out_inst)
    );

    always #4 clk = ~clk;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            lfsr_next = (state >> 1) ^ 32'h80200003;
        end else begin
            lfsr_next = state >> 1;
        end
    endfunction

    task automatic compare_inst(input inst_word_u exp_inst, input inst_word_u act_inst);
        if (act_inst !== exp_inst) begin
            $display("ERR %0t out_inst expected %h actual %h", $time, exp_inst, act_inst);
            inst_errors++;
        end
    endtask

    task automatic compare_tag(input logic [`UOP_UUID_W-1:0] exp_uuid,
                               input logic [`UOP_UUID_W-1:0] act_uuid,
                               input logic [`UOP_NUM_THREADS-1:0] exp_tmask,
                               input logic [`UOP_NUM_THREADS-1:0] act_tmask);
        if (act_uuid !== exp_uuid) begin
            $display("ERR %0t out_uuid expected %h actual %h", $time, exp_uuid, act_uuid);
            tag_errors++;
        end
        if (act_tmask !== exp_tmask) begin
            $display("ERR %0t out_tmask expected %h actual %h", $time, exp_tmask, act_tmask);
            tag_errors++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          got;
        int          fields;
        string       line;
        logic [7:0]  kind;
        logic [31:0] uuid_val;
        logic [31:0] tmask_val;
        logic [31:0] word_val;
        fd = $fopen("dv/uop_seq_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/uop_seq_trace.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // blank lines and comment lines carry no data
                if (got != 0 && line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%c %h %h %h", kind, uuid_val, tmask_val, word_val);
                    if (fields != 4) begin
                        $display("malformed trace line: %s", line);
                        other_errors++;
                    end else if (kind == "I") begin
                        in_uuid_q.push_back(uuid_val[`UOP_UUID_W-1:0]);
                        in_tmask_q.push_back(tmask_val[`UOP_NUM_THREADS-1:0]);
                        in_inst_q.push_back(word_val);
                    end else if (kind == "E") begin
                        exp_uuid_q.push_back(uuid_val[`UOP_UUID_W-1:0]);
                        exp_tmask_q.push_back(tmask_val[`UOP_NUM_THREADS-1:0]);
                        exp_inst_q.push_back(word_val);
                    end else begin
                        $display("unknown record kind in trace line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // source side, the current word is held until the DUT takes it
    always @(posedge clk) begin
        if (reset) begin
            in_valid  <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            if (in_taken) begin
                in_idx = in_idx + 1;
            end
            if (in_idx < in_inst_q.size()) begin
                in_valid <= 1'b1;
                in_uuid  <= in_uuid_q[in_idx];
                in_tmask <= in_tmask_q[in_idx];
                in_inst  <= in_inst_q[in_idx];
            end else begin
                in_valid <= 1'b0;
                in_uuid  <= '0;
                in_tmask <= '0;
                in_inst  <= '0;
            end
            // sink stalls on roughly half the cycles
            lfsr = lfsr_next(lfsr);
            out_ready <= ~lfsr[0];
        end
    end

    // handshakes are settled mid-cycle, so both streams are sampled on the falling edge
    always @(negedge clk) begin
        in_taken = 1'b0;
        if (!reset) begin
            if (in_valid && in_ready) begin
                in_taken = 1'b1;
                in_count++;
            end
            if (out_valid && out_ready) begin
                out_count++;
                if (exp_inst_q.size() == 0) begin
                    $display("output transfer at %0t with no expected transfer left", $time);
                    other_errors++;
                end else begin
                    compare_tag(exp_uuid_q.pop_front(), out_uuid,
                                exp_tmask_q.pop_front(), out_tmask);
                    compare_inst(exp_inst_q.pop_front(), out_inst);
                end
            end
        end
    end

    initial begin
        int   n_in;
        int   n_exp;
        int   limit;
        int   cycles;
        logic timed_out;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_uuid   = '0;
        in_tmask  = '0;
        in_inst   = '0;
        out_ready = 1'b0;
        load_trace();
        n_in   = in_inst_q.size();
        n_exp  = exp_inst_q.size();
        limit  = 4 * n_exp + 50;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        cycles    = 0;
        timed_out = 1'b0;
        while (!(in_count == n_in && out_count == n_exp) && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles >= limit) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, %0d of %0d inputs taken, %0d of %0d outputs seen",
                     cycles, in_count, n_in, out_count, n_exp);
            other_errors++;
        end
        // a few idle cycles so that a stray extra transfer is caught
        repeat (6) @(posedge clk);
        if (exp_inst_q.size() != 0) begin
            $display("%0d expected output transfers never appeared", exp_inst_q.size());
            other_errors++;
        end
        if (in_count != n_in) begin
            $display("%0d inputs were taken but the trace holds %0d", in_count, n_in);
            other_errors++;
        end
        $display("inst errors %0d, tag errors %0d, other errors %0d",
                 inst_errors, tag_errors, other_errors);
        if (inst_errors + tag_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- dv/uop_seq_trace.txt
# columns: kind uuid tmask word, all in hex
# kind I is an instruction into the sequencer, kind E an expected output transfer in order
# scalar word passes through unchanged
I 11 f 2a5c3180
E 11 f 2a5c3180
# set 0, a=31 b=30 c=31 d=31
I 22 3 a7fdff80
E 22 3 523fff7c
E 22 3 52400f00
E 22 3 52bffffc
E 22 3 52c00f80
E 22 3 533ff07c
E 22 3 53400000
E 22 3 53bff0fc
E 22 3 53c00080
# set 1 right behind set 0, a=29 b=2 c=30 d=28
I 23 a af45ee00
E 23 a 523df100
E 23 a 527e0104
E 23 a 52bdf180
E 23 a 52fe0184
E 23 a 533df200
E 23 a 537e0204
E 23 a 53bdf280
E 23 a 53fe0284
# scalar right behind a tensor word
I 34 5 6e014c08
E 34 5 6e014c08
# set 2, a=0 b=29 c=27 d=26
I 45 c b03bbd00
E 45 c 523c4efc
E 45 c 527e5e80
E 45 c 52bc4f7c
E 45 c 52fe5f00
E 45 c 533c4ffc
E 45 c 537e5f80
E 45 c 53bc407c
E 45 c 53fe5000
# set 3, a=25 b=31 c=26 d=3
I 56 9 be7fa180
E 56 9 5213ff80
E 56 9 52540f84
E 56 9 5293f000
E 56 9 52d40004
E 56 9 5313f080
E 56 9 53540084
E 56 9 5393f100
E 56 9 53d40104
# scalar carrying the FMA code still passes through
I 67 1 4b2d8e60
E 67 1 4b2d8e60

//--- hdl/ucode_rom.sv
`timescale 1ns/1ps

`include "uop_defs.svh"

module ucode_rom (
    input  logic [`UOP_UPC_BITS-1:0] upc,
    output logic [3:0]               op_type,
    output logic [2:0]               op_mod,
    output logic [`UOP_REG_BITS-1:0] rd_off,
    output logic [`UOP_REG_BITS-1:0] rs1_off,
    output logic [`UOP_REG_BITS-1:0] rs2_off,
    output logic [`UOP_REG_BITS-1:0] rs3_off,
    output logic                     last
);

    // one row is {op_type, op_mod, rd_off, rs1_off, rs2_off, rs3_off, last}
    localparam int ROW_W = 4 + 3 + 4 * `UOP_REG_BITS + 1;

    logic [ROW_W-1:0] row;

    // set s, step k sits at 8s+k
    // rd and rs3 walk the accumulator pair of the set, rs1 the A pair, rs2 the B column
    always_comb begin
        case (upc)
            // set 0
            5'd0:  row = {4'h9, 3'd0, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0};
            5'd1:  row = {4'h9, 3'd1, 5'd1, 5'd1, 5'd0, 5'd1, 1'b0};
            5'd2:  row = {4'h9, 3'd2, 5'd0, 5'd0, 5'd1, 5'd0, 1'b0};
            5'd3:  row = {4'h9, 3'd3, 5'd1, 5'd1, 5'd1, 5'd1, 1'b0};
            5'd4:  row = {4'h9, 3'd4, 5'd0, 5'd0, 5'd2, 5'd0, 1'b0};
            5'd5:  row = {4'h9, 3'd5, 5'd1, 5'd1, 5'd2, 5'd1, 1'b0};
            5'd6:  row = {4'h9, 3'd6, 5'd0, 5'd0, 5'd3, 5'd0, 1'b0};
            5'd7:  row = {4'h9, 3'd7, 5'd1, 5'd1, 5'd3, 5'd1, 1'b1};
            // set 1
            5'd8:  row = {4'h9, 3'd0, 5'd2, 5'd2, 5'd0, 5'd2, 1'b0};
            5'd9:  row = {4'h9, 3'd1, 5'd3, 5'd3, 5'd0, 5'd3, 1'b0};
            5'd10: row = {4'h9, 3'd2, 5'd2, 5'd2, 5'd1, 5'd2, 1'b0};
            5'd11: row = {4'h9, 3'd3, 5'd3, 5'd3, 5'd1, 5'd3, 1'b0};
            5'd12: row = {4'h9, 3'd4, 5'd2, 5'd2, 5'd2, 5'd2, 1'b0};
            5'd13: row = {4'h9, 3'd5, 5'd3, 5'd3, 5'd2, 5'd3, 1'b0};
            5'd14: row = {4'h9, 3'd6, 5'd2, 5'd2, 5'd3, 5'd2, 1'b0};
            5'd15: row = {4'h9, 3'd7, 5'd3, 5'd3, 5'd3, 5'd3, 1'b1};
            // set 2
            5'd16: row = {4'h9, 3'd0, 5'd4, 5'd4, 5'd0, 5'd4, 1'b0};
            5'd17: row = {4'h9, 3'd1, 5'd5, 5'd5, 5'd0, 5'd5, 1'b0};
            5'd18: row = {4'h9, 3'd2, 5'd4, 5'd4, 5'd1, 5'd4, 1'b0};
            5'd19: row = {4'h9, 3'd3, 5'd5, 5'd5, 5'd1, 5'd5, 1'b0};
            5'd20: row = {4'h9, 3'd4, 5'd4, 5'd4, 5'd2, 5'd4, 1'b0};
            5'd21: row = {4'h9, 3'd5, 5'd5, 5'd5, 5'd2, 5'd5, 1'b0};
            5'd22: row = {4'h9, 3'd6, 5'd4, 5'd4, 5'd3, 5'd4, 1'b0};
            5'd23: row = {4'h9, 3'd7, 5'd5, 5'd5, 5'd3, 5'd5, 1'b1};
            // set 3
            5'd24: row = {4'h9, 3'd0, 5'd6, 5'd6, 5'd0, 5'd6, 1'b0};
            5'd25: row = {4'h9, 3'd1, 5'd7, 5'd7, 5'd0, 5'd7, 1'b0};
            5'd26: row = {4'h9, 3'd2, 5'd6, 5'd6, 5'd1, 5'd6, 1'b0};
            5'd27: row = {4'h9, 3'd3, 5'd7, 5'd7, 5'd1, 5'd7, 1'b0};
            5'd28: row = {4'h9, 3'd4, 5'd6, 5'd6, 5'd2, 5'd6, 1'b0};
            5'd29: row = {4'h9, 3'd5, 5'd7, 5'd7, 5'd2, 5'd7, 1'b0};
            5'd30: row = {4'h9, 3'd6, 5'd6, 5'd6, 5'd3, 5'd6, 1'b0};
            5'd31: row = {4'h9, 3'd7, 5'd7, 5'd7, 5'd3, 5'd7, 1'b1};
            default: begin
                row = '0;
            end
        endcase
    end

    assign {op_type, op_mod, rd_off, rs1_off, rs2_off, rs3_off, last} = row;

endmodule

//--- hdl/uop_compose.sv
`timescale 1ns/1ps

`include "uop_defs.svh"

module uop_compose (
    input  logic                     seq_active,
    input  uop_pkg::inst_word_u      in_inst,
    input  logic [3:0]               op_type,
    input  logic [2:0]               op_mod,
    input  logic [`UOP_REG_BITS-1:0] rd_off,
    input  logic [`UOP_REG_BITS-1:0] rs1_off,
    input  logic [`UOP_REG_BITS-1:0] rs2_off,
    input  logic [`UOP_REG_BITS-1:0] rs3_off,
    output uop_pkg::inst_word_u      out_inst
);

    import uop_pkg::*;

    inst_word_u uop_word;

    logic [`UOP_REG_BITS-1:0] rd_sum;
    logic [`UOP_REG_BITS-1:0] rs1_sum;
    logic [`UOP_REG_BITS-1:0] rs2_sum;
    logic [`UOP_REG_BITS-1:0] rs3_sum;

    // register numbers wrap around the 32-entry register file
    assign rd_sum  = in_inst.tensor.d_base + rd_off;
    assign rs1_sum = in_inst.tensor.a_base + rs1_off;
    assign rs2_sum = in_inst.tensor.b_base + rs2_off;
    assign rs3_sum = in_inst.tensor.c_base + rs3_off;

    // the micro-op is an ordinary scalar FMA word as seen by the next stage
    always_comb begin
        uop_word                = '0;
        uop_word.scalar.ex_type = `UOP_EX_FMA;
        uop_word.scalar.op_type = op_type;
        uop_word.scalar.op_mod  = op_mod;
        uop_word.scalar.rd      = rd_sum;
        uop_word.scalar.rs1     = rs1_sum;
        uop_word.scalar.rs2     = rs2_sum;
        uop_word.scalar.rs3     = rs3_sum;
    end

    // outside a sequence the incoming word goes through untouched
    assign out_inst = seq_active ? uop_word : in_inst;

endmodule

//--- hdl/uop_ctrl_fsm.sv
`timescale 1ns/1ps

`include "uop_defs.svh"

module uop_ctrl_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  uop_pkg::inst_word_u      in_inst,
    input  logic                     out_ready,
    input  logic                     last,
    output logic                     in_ready,
    output logic                     out_valid,
    output logic                     seq_active,
    output logic                     upc_load,
    output logic                     upc_advance,
    output logic [`UOP_UPC_BITS-1:0] entry
);

    localparam logic STATE_IDLE = 1'b0;
    localparam logic STATE_SEQ  = 1'b1;

    logic state;
    logic state_next;
    logic is_tensor;
    logic start;
    logic uop_fire;

    assign is_tensor = (in_inst.tensor.ex_type == `UOP_EX_TENSOR);

    // a tensor word waiting in idle starts sequencing in the same cycle
    assign start = (state == STATE_IDLE) && in_valid && is_tensor;

    assign seq_active = start || (state == STATE_SEQ);

    // each register set owns eight consecutive table entries
    assign entry = `UOP_UPC_BITS'(`UOP_STEPS * in_inst.tensor.set_sel);

    assign upc_load = start;

    // the input is held while its micro-ops are emitted, so valid stays high
    assign out_valid = seq_active ? 1'b1 : in_valid;

    assign uop_fire    = seq_active && out_ready;
    assign upc_advance = uop_fire;

    // the tensor word is consumed together with its final micro-op
    assign in_ready = seq_active ? (uop_fire && last) : out_ready;

    always_comb begin
        state_next = state;
        case (state)
            STATE_IDLE: begin
                if (start) begin
                    if (uop_fire && last) begin
                        state_next = STATE_IDLE;
                    end else begin
                        state_next = STATE_SEQ;
                    end
                end
            end
            STATE_SEQ: begin
                // back to idle right after the last step so a new word can start at once
                if (uop_fire && last) begin
                    state_next = STATE_IDLE;
                end
            end
            default: begin
                state_next = STATE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- hdl/uop_defs.svh
`ifndef UOP_DEFS_SVH
`define UOP_DEFS_SVH

// tag and thread mask carried by every instruction on the issue path
`define UOP_UUID_W 8
`define UOP_NUM_THREADS 4

// instruction word and register number widths
`define UOP_INST_W 32
`define UOP_REG_BITS 5

// microcode table layout, four register sets of eight steps each
`define UOP_TABLE_SIZE 32
`define UOP_UPC_BITS 5
`define UOP_STEPS 8

// execution unit codes found in the top bits of the instruction word
`define UOP_EX_BITS 3
`define UOP_EX_TENSOR 3'd5
`define UOP_EX_FMA 3'd2

`endif

//--- hdl/uop_pkg.sv
`include "uop_defs.svh"

package uop_pkg;

    // one instruction word with two decodings that share ex_type at the top
    // the tensor view applies when ex_type is the tensor code, the scalar view otherwise
    typedef union packed {
        struct packed {
            logic [`UOP_EX_BITS-1:0]  ex_type;
            logic [3:0]               op_type;
            logic [2:0]               op_mod;
            logic [`UOP_REG_BITS-1:0] rd;
            logic [`UOP_REG_BITS-1:0] rs1;
            logic [`UOP_REG_BITS-1:0] rs2;
            logic [`UOP_REG_BITS-1:0] rs3;
            logic [1:0]               pad;
        } scalar;
        struct packed {
            logic [`UOP_EX_BITS-1:0]  ex_type;
            // selects one of the four register sets in the microcode table
            logic [1:0]               set_sel;
            logic [`UOP_REG_BITS-1:0] a_base;
            logic [`UOP_REG_BITS-1:0] b_base;
            logic [`UOP_REG_BITS-1:0] c_base;
            logic [`UOP_REG_BITS-1:0] d_base;
            logic [6:0]               pad;
        } tensor;
    } inst_word_u;

endpackage

//--- hdl/uop_sequencer_top.sv
`timescale 1ns/1ps

`include "uop_defs.svh"

module uop_sequencer_top (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`UOP_UUID_W-1:0]      in_uuid,
    input  logic [`UOP_NUM_THREADS-1:0] in_tmask,
    input  uop_pkg::inst_word_u         in_inst,

    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`UOP_UUID_W-1:0]      out_uuid,
    output logic [`UOP_NUM_THREADS-1:0] out_tmask,
    output uop_pkg::inst_word_u         out_inst
);

    logic                     seq_active;
    logic                     upc_load;
    logic                     upc_advance;
    logic [`UOP_UPC_BITS-1:0] entry;
    logic [`UOP_UPC_BITS-1:0] upc;
    logic [3:0]               op_type;
    logic [2:0]               op_mod;
    logic [`UOP_REG_BITS-1:0] rd_off;
    logic [`UOP_REG_BITS-1:0] rs1_off;
    logic [`UOP_REG_BITS-1:0] rs2_off;
    logic [`UOP_REG_BITS-1:0] rs3_off;
    logic                     last;

    // every micro-op inherits the tag and thread mask of its parent
    assign out_uuid  = in_uuid;
    assign out_tmask = in_tmask;

    uop_ctrl_fsm i_uop_ctrl_fsm (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .out_ready   (out_ready),
        .last        (last),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .seq_active  (seq_active),
        .upc_load    (upc_load),
        .upc_advance (upc_advance),
        .entry       (entry)
    );

    upc_counter i_upc_counter (
        .clk         (clk),
        .reset       (reset),
        .upc_load    (upc_load),
        .upc_advance (upc_advance),
        .entry       (entry),
        .upc         (upc)
    );

    ucode_rom i_ucode_rom (
        .upc     (upc),
        .op_type (op_type),
        .op_mod  (op_mod),
        .rd_off  (rd_off),
        .rs1_off (rs1_off),
        .rs2_off (rs2_off),
        .rs3_off (rs3_off),
        .last    (last)
    );

    uop_compose i_uop_compose (
        .seq_active (seq_active),
        .in_inst    (in_inst),
        .op_type    (op_type),
        .op_mod     (op_mod),
        .rd_off     (rd_off),
        .rs1_off    (rs1_off),
        .rs2_off    (rs2_off),
        .rs3_off    (rs3_off),
        .out_inst   (out_inst)
    );

endmodule

//--- hdl/upc_counter.sv
`timescale 1ns/1ps

`include "uop_defs.svh"

module upc_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     upc_load,
    input  logic                     upc_advance,
    input  logic [`UOP_UPC_BITS-1:0] entry,
    output logic [`UOP_UPC_BITS-1:0] upc
);

    logic [`UOP_UPC_BITS-1:0] upc_r;
    logic [`UOP_UPC_BITS-1:0] upc_next;

    // the entry point bypasses the register so step zero is on the output
    // in the same cycle the tensor word arrives
    assign upc = upc_load ? entry : upc_r;

    always_comb begin
        if (upc_advance) begin
            // sequences are laid out contiguously, the next step is always one up
            upc_next = upc + `UOP_UPC_BITS'(1);
        end else begin
            // under back-pressure the current step is kept, including a fresh entry point
            upc_next = upc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            upc_r <= '0;
        end else begin
            upc_r <= upc_next;
        end
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/uop_pkg.sv
hdl/uop_ctrl_fsm.sv
hdl/upc_counter.sv
hdl/ucode_rom.sv
hdl/uop_compose.sv
hdl/uop_sequencer_top.sv
dv/uop_seq_tb.sv
